// ==== compile.f ====
div_ctrl_pkg.sv
srt_qds_pkg.sv
lzc.sv
div_ctrl.sv
div_prescale.sv
srt_iter.sv
div_postproc.sv
srt_div.sv
srt_div_props.sv
tb_srt_div.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_srt_div
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator status is ignored here, the log decides
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "RESULT: FAIL"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "RESULT: FAIL, run ended early"; exit 1; }
	@echo "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_srt_div.sv ====
`timescale 1ns/1ns

module tb_srt_div;

	localparam int XLEN       = 32;
	localparam int N_OPS      = 2000; // corner operations included
	localparam int N_CORNER   = 18;
	localparam int CYC_PER_OP = 40; // up to 16 digit cycles plus stall and handshake slack
	localparam int CYC_LIMIT  = N_OPS * CYC_PER_OP;

	logic            clock;
	logic            rst_n;
	logic            in_valid;
	logic            in_ready;
	logic            signed_op;
	logic [XLEN-1:0] dividend;
	logic [XLEN-1:0] divisor;
	logic            out_valid;
	logic            out_ready;
	logic [XLEN-1:0] quot;
	logic [XLEN-1:0] rem;
	logic            divisor_zero;
	logic [31:0]     lfsr;
	int              cycles = 0;
	int              errors = 0;

	srt_div #(.XLEN(XLEN)) u_dut (
		.clock_i        (clock),
		.rst_n_i        (rst_n),
		.in_valid_i     (in_valid),
		.in_ready_o     (in_ready),
		.signed_i       (signed_op),
		.dividend_i     (dividend),
		.divisor_i      (divisor),
		.out_valid_o    (out_valid),
		.out_ready_i    (out_ready),
		.quot_o         (quot),
		.rem_o          (rem),
		.divisor_zero_o (divisor_zero)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period
	end

	task automatic abort_run(input string why);
		errors++;
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	always @(posedge clock) begin
		cycles++;
		if (cycles >= CYC_LIMIT) begin
			abort_run($sformatf("timeout: %0d cycles passed and the tests did not finish",
				cycles));
		end
	end

	// galois lfsr stepped once per bit taken with the bit leaving at the bottom as output
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// expected results by the risc-v division rules
	task automatic model_div(input logic sgn, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b, output logic [XLEN-1:0] q, output logic [XLEN-1:0] r,
		output logic dz);
		dz = (b == '0);
		if (dz) begin
			q = '1;
			r = a;
		end else if (sgn && a == {1'b1, {(XLEN-1){1'b0}}} && b == '1) begin
			q = a; // overflow case keeps the dividend
			r = '0;
		end else if (sgn) begin
			q = $signed(a) / $signed(b); // truncates toward zero and the remainder takes the dividend sign
			r = $signed(a) % $signed(b);
		end else begin
			q = a / b;
			r = a % b;
		end
	endtask

	task automatic check_word(input string name, input logic [XLEN-1:0] exp_v,
		input logic [XLEN-1:0] act_v);
		if (act_v !== exp_v) begin
			abort_run($sformatf("MISMATCH at %0t: %s expected %h, got %h", $time, name,
				exp_v, act_v));
		end
	endtask

	task automatic check_flag(input string name, input logic exp_v, input logic act_v);
		if (act_v !== exp_v) begin
			abort_run($sformatf("MISMATCH at %0t: %s expected %b, got %b", $time, name,
				exp_v, act_v));
		end
	endtask

	// one full transfer with a random stall of 0 to 3 cycles on the output side
	task automatic transfer_op(input logic sgn, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		logic [XLEN-1:0] exp_q;
		logic [XLEN-1:0] exp_r;
		logic            exp_dz;
		logic [1:0]      stall;
		model_div(sgn, a, b, exp_q, exp_r, exp_dz);
		stall = 2'(rand_bits(2));
		while (!in_ready) @(negedge clock);
		in_valid  = 1'b1; // handshake happens on the next rising edge
		signed_op = sgn;
		dividend  = a;
		divisor   = b;
		@(negedge clock);
		in_valid = 1'b0;
		while (!out_valid) begin
			check_flag("in_ready_o", 1'b0, in_ready); // nothing new may be taken while busy
			@(negedge clock);
		end
		repeat (stall) begin
			check_word("quot_o", exp_q, quot); // result must hold while out_ready_i is low
			check_word("rem_o", exp_r, rem);
			check_flag("divisor_zero_o", exp_dz, divisor_zero);
			check_flag("out_valid_o", 1'b1, out_valid);
			check_flag("in_ready_o", 1'b0, in_ready);
			@(negedge clock);
		end
		check_word("quot_o", exp_q, quot);
		check_word("rem_o", exp_r, rem);
		check_flag("divisor_zero_o", exp_dz, divisor_zero);
		out_ready = 1'b1;
		@(negedge clock);
		out_ready = 1'b0;
	endtask

	task automatic corner_ops();
		transfer_op(1'b1, 32'h8000_0000, 32'hffff_ffff); // most negative over minus one
		transfer_op(1'b0, 32'h8000_0000, 32'hffff_ffff);
		transfer_op(1'b0, 32'd3, 32'd7); // dividend below the divisor
		transfer_op(1'b1, -32'sd3, 32'd7);
		transfer_op(1'b1, 32'd3, -32'sd7);
		transfer_op(1'b0, 32'hffff_ffff, 32'd1); // divisor of one
		transfer_op(1'b0, 32'h8000_0001, 32'd1);
		transfer_op(1'b0, 32'h7fff_ffff, 32'd1);
		transfer_op(1'b1, -32'sd5, 32'd1);
		transfer_op(1'b1, 32'd5, 32'hffff_ffff);
		transfer_op(1'b0, 32'd0, 32'd5); // dividend of zero
		transfer_op(1'b1, 32'd0, -32'sd3);
		transfer_op(1'b0, 32'd0, 32'd0);
		transfer_op(1'b0, 32'd12345, 32'd0); // zero divisor
		transfer_op(1'b1, -32'sd7, 32'd0);
		transfer_op(1'b1, 32'h8000_0000, 32'd0);
		transfer_op(1'b0, 32'hdead_beef, 32'hdead_beef);
		transfer_op(1'b1, -32'sd100, 32'sd7);
	endtask

	task automatic random_ops(input int n);
		logic            sgn;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		for (int i = 0; i < n; i++) begin
			sgn = 1'(rand_bits(1));
			a   = rand_bits(32);
			if (rand_bits(1)) a = a >> rand_bits(5); // spread the dividend width
			b = rand_bits(32) >> rand_bits(5);
			if (sgn && rand_bits(1)) b = -b; // small negative divisors too
			if (rand_bits(4) == 0) b = '0;
			transfer_op(sgn, a, b);
		end
	endtask

	initial begin
		lfsr      = 32'hd190_78ef;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		signed_op = 1'b0;
		dividend  = '0;
		divisor   = '0;
		out_ready = 1'b0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		check_flag("in_ready_o", 1'b1, in_ready);
		check_flag("out_valid_o", 1'b0, out_valid);
		corner_ops();
		random_ops(N_OPS - N_CORNER);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== srt_div_props.sv ====
`timescale 1ns/1ns

module srt_div_props #(
	parameter int XLEN = 32
) (
	input logic            clock_i,
	input logic            rst_n_i,
	input logic            in_ready_o,
	input logic            out_valid_o,
	input logic            out_ready_i,
	input logic [XLEN-1:0] quot_o,
	input logic [XLEN-1:0] rem_o,
	input logic            divisor_zero_o
);

	// idle and result-offered are separate states, so both sides never open together
	a_ready_valid_excl: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		!(in_ready_o && out_valid_o)) else $error("in_ready_o and out_valid_o high together");

	// a stalled result stays offered and does not move
	a_stall_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(quot_o) && $stable(rem_o)
		&& $stable(divisor_zero_o)) else $error("stalled result changed or dropped");

	// first edge after reset release still sees no result
	a_first_cycle: assert property (@(posedge clock_i) $rose(rst_n_i) |-> !out_valid_o)
		else $error("out_valid_o high right after reset");

endmodule

bind srt_div srt_div_props #(.XLEN(XLEN)) u_props (
	.clock_i        (clock_i),
	.rst_n_i        (rst_n_i),
	.in_ready_o     (in_ready_o),
	.out_valid_o    (out_valid_o),
	.out_ready_i    (out_ready_i),
	.quot_o         (quot_o),
	.rem_o          (rem_o),
	.divisor_zero_o (divisor_zero_o)
);

// ==== srt_div.sv ====
`timescale 1ns/1ns

module srt_div #(
	parameter int XLEN = 32
) (
	input  logic            clock_i,
	input  logic            rst_n_i,
	input  logic            in_valid_i,
	output logic            in_ready_o,
	input  logic            signed_i,
	input  logic [XLEN-1:0] dividend_i,
	input  logic [XLEN-1:0] divisor_i,
	output logic            out_valid_o,
	input  logic            out_ready_i,
	output logic [XLEN-1:0] quot_o,
	output logic [XLEN-1:0] rem_o,
	output logic            divisor_zero_o
);

	import div_ctrl_pkg::*;

	localparam int CNT_W = $clog2(XLEN);

	div_state_e       state;
	logic             skip_iter;
	logic             final_iter;
	logic [XLEN-1:0]  dividend_abs;
	logic [XLEN-1:0]  dividend_norm;
	logic [XLEN-1:0]  divisor_norm;
	logic             divisor_zero;
	logic             too_big;
	logic             too_small;
	logic [CNT_W-1:0] iter_cnt;
	logic             lzc_odd;
	logic [CNT_W-1:0] rem_shift;
	logic             quot_neg;
	logic             rem_neg;
	logic [XLEN+3:0]  rem_sum;
	logic [XLEN+3:0]  rem_carry;
	logic [XLEN-1:0]  quot;
	logic [XLEN-1:0]  quot_m1;

	div_ctrl u_ctrl (
		.clock_i      (clock_i),
		.rst_n_i      (rst_n_i),
		.in_valid_i   (in_valid_i),
		.out_ready_i  (out_ready_i),
		.skip_iter_i  (skip_iter),
		.final_iter_i (final_iter),
		.state_o      (state),
		.in_ready_o   (in_ready_o),
		.out_valid_o  (out_valid_o)
	);

	div_prescale #(.XLEN(XLEN)) u_prescale (
		.clock_i         (clock_i),
		.rst_n_i         (rst_n_i),
		.state_i         (state),
		.in_valid_i      (in_valid_i),
		.signed_i        (signed_i),
		.dividend_i      (dividend_i),
		.divisor_i       (divisor_i),
		.dividend_abs_o  (dividend_abs),
		.dividend_norm_o (dividend_norm),
		.divisor_norm_o  (divisor_norm),
		.divisor_zero_o  (divisor_zero),
		.too_big_o       (too_big),
		.too_small_o     (too_small),
		.skip_iter_o     (skip_iter),
		.iter_cnt_o      (iter_cnt),
		.lzc_odd_o       (lzc_odd),
		.rem_shift_o     (rem_shift),
		.quot_neg_o      (quot_neg),
		.rem_neg_o       (rem_neg)
	);

	srt_iter #(.XLEN(XLEN)) u_iter (
		.clock_i         (clock_i),
		.rst_n_i         (rst_n_i),
		.state_i         (state),
		.dividend_abs_i  (dividend_abs),
		.dividend_norm_i (dividend_norm),
		.divisor_norm_i  (divisor_norm),
		.divisor_zero_i  (divisor_zero),
		.too_big_i       (too_big),
		.too_small_i     (too_small),
		.iter_cnt_i      (iter_cnt),
		.lzc_odd_i       (lzc_odd),
		.rem_sum_o       (rem_sum),
		.rem_carry_o     (rem_carry),
		.quot_o          (quot),
		.quot_m1_o       (quot_m1),
		.final_iter_o    (final_iter)
	);

	div_postproc #(.XLEN(XLEN)) u_postproc (
		.clock_i        (clock_i),
		.rst_n_i        (rst_n_i),
		.state_i        (state),
		.rem_sum_i      (rem_sum),
		.rem_carry_i    (rem_carry),
		.quot_i         (quot),
		.quot_m1_i      (quot_m1),
		.divisor_norm_i (divisor_norm),
		.rem_shift_i    (rem_shift),
		.quot_neg_i     (quot_neg),
		.rem_neg_i      (rem_neg),
		.divisor_zero_i (divisor_zero),
		.too_big_i      (too_big),
		.quot_o         (quot_o),
		.rem_o          (rem_o),
		.divisor_zero_o (divisor_zero_o)
	);

endmodule

// ==== div_postproc.sv ====
`timescale 1ns/1ns

module div_postproc #(
	parameter int XLEN = 32
) (
	input  logic                     clock_i,
	input  logic                     rst_n_i,
	input  div_ctrl_pkg::div_state_e state_i,
	input  logic [XLEN+3:0]          rem_sum_i,
	input  logic [XLEN+3:0]          rem_carry_i,
	input  logic [XLEN-1:0]          quot_i,
	input  logic [XLEN-1:0]          quot_m1_i,
	input  logic [XLEN-1:0]          divisor_norm_i,
	input  logic [$clog2(XLEN)-1:0]  rem_shift_i,
	input  logic                     quot_neg_i,
	input  logic                     rem_neg_i,
	input  logic                     divisor_zero_i,
	input  logic                     too_big_i,
	output logic [XLEN-1:0]          quot_o,
	output logic [XLEN-1:0]          rem_o,
	output logic                     divisor_zero_o
);

	import div_ctrl_pkg::*;
	import srt_qds_pkg::*;

	localparam int REM_W = XLEN + 4;

	logic [REM_W-1:0] rem_full;
	logic [REM_W-1:0] rem_plus_d;
	logic             need_corr;
	quot_digit_e      corr_digit;
	logic [XLEN-1:0]  quot_mag;
	logic [XLEN-1:0]  rem_mag;
	logic [XLEN-1:0]  rem_shifted;

	assign rem_full   = rem_sum_i + rem_carry_i; // the low three bits end up zero
	assign rem_plus_d = rem_full + {1'b0, divisor_norm_i, 3'b000};

	// a negative last remainder means the quotient came out one too high
	assign need_corr  = rem_full[REM_W-1] & ~divisor_zero_i & ~too_big_i;
	assign corr_digit = need_corr ? Q_NEG1 : Q_ZERO;

	assign quot_mag    = (corr_digit == Q_NEG1) ? quot_m1_i : quot_i;
	assign rem_mag     = need_corr ? rem_plus_d[XLEN+2:3] : rem_full[XLEN+2:3];
	assign rem_shifted = rem_mag >> rem_shift_i; // back to the scale of the original divisor

	always_ff @(posedge clock_i) begin
		if (state_i == POS0) begin
			quot_o <= quot_neg_i ? -quot_mag : quot_mag;
			rem_o  <= rem_neg_i ? -rem_shifted : rem_shifted;
		end
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) divisor_zero_o <= 1'b0;
		else if (state_i == POS0) divisor_zero_o <= divisor_zero_i;
	end

endmodule

// ==== srt_iter.sv ====
`timescale 1ns/1ns

module srt_iter #(
	parameter int XLEN = 32
) (
	input  logic                     clock_i,
	input  logic                     rst_n_i,
	input  div_ctrl_pkg::div_state_e state_i,
	input  logic [XLEN-1:0]          dividend_abs_i,
	input  logic [XLEN-1:0]          dividend_norm_i,
	input  logic [XLEN-1:0]          divisor_norm_i,
	input  logic                     divisor_zero_i,
	input  logic                     too_big_i,
	input  logic                     too_small_i,
	input  logic [$clog2(XLEN)-1:0]  iter_cnt_i,
	input  logic                     lzc_odd_i,
	output logic [XLEN+3:0]          rem_sum_o,
	output logic [XLEN+3:0]          rem_carry_o,
	output logic [XLEN-1:0]          quot_o,
	output logic [XLEN-1:0]          quot_m1_o,
	output logic                     final_iter_o
);

	import div_ctrl_pkg::*;
	import srt_qds_pkg::*;

	localparam int CNT_W = $clog2(XLEN);
	localparam int REM_W = XLEN + 4; // sign at the top, divisor LSB at bit 3

	logic [QDS_IDX_W-1:0] row;
	logic [REM_W-1:0]     rem_init;
	logic [REM_W-1:0]     rem_load;
	logic [4:0]           pre_est;
	quot_digit_e          pre_digit;
	quot_digit_e          digit_q;
	quot_digit_e          digit_nxt;
	logic [4:0]           m_neg1_q;
	logic [2:0]           m_neg0_q;
	logic [1:0]           m_pos1_q;
	logic [4:0]           m_pos2_q;
	logic signed [6:0]    th_neg1;
	logic signed [6:0]    th_neg0;
	logic signed [6:0]    th_pos1;
	logic signed [6:0]    th_pos2;
	logic [REM_W-1:0]     dvs_x1;
	logic [REM_W-1:0]     dvs_x2;
	logic [REM_W-1:0]     csa_a;
	logic [REM_W-1:0]     csa_b;
	logic [REM_W-1:0]     csa_c;
	logic [REM_W-1:0]     maj;
	logic [REM_W-1:0]     sum_nxt;
	logic [REM_W-1:0]     carry_nxt;
	logic signed [6:0]    y_est;
	logic [CNT_W-1:0]     cnt_q;
	logic [XLEN-1:0]      quot_nxt;
	logic [XLEN-1:0]      quot_m1_nxt;

	assign row = divisor_norm_i[XLEN-2 -: QDS_IDX_W]; // bits right below the leading one

	// the initial remainder is the dividend over four, or over eight for an odd difference
	assign rem_init = lzc_odd_i ? {4'b0000, dividend_norm_i} : {3'b000, dividend_norm_i, 1'b0};
	assign rem_load = (too_small_i | divisor_zero_i) ? {1'b0, dividend_abs_i, 3'b000} :
		too_big_i ? '0 : rem_init;

	assign pre_est   = {1'b0, rem_init[XLEN -: 4]}; // four times the start value in sixteenths
	assign pre_digit = (pre_est >= pre_m_pos2(row)) ? Q_POS2 :
		(pre_est >= pre_m_pos1(row)) ? Q_POS1 : Q_ZERO;

	assign th_pos2 = $signed({2'b00, m_pos2_q});
	assign th_pos1 = $signed({3'b000, ({1'b0, m_pos1_q} + 3'd2), 1'b0});
	assign th_neg0 = -$signed({3'b000, m_neg0_q, 1'b0});
	assign th_neg1 = -$signed({2'b00, m_neg1_q});

	assign dvs_x1 = {1'b0, divisor_norm_i, 3'b000};
	assign dvs_x2 = {divisor_norm_i, 4'b0000}; // wraps past the sign, the sum still fits
	assign csa_a  = {rem_sum_o[REM_W-3:0], 2'b00}; // radix-4 shift of the partial remainder
	assign csa_b  = {rem_carry_o[REM_W-3:0], 2'b00};

	always_comb begin
		unique case (digit_q)
			Q_NEG2: csa_c = dvs_x2;
			Q_NEG1: csa_c = dvs_x1;
			Q_POS1: csa_c = ~dvs_x1; // the missing +1 enters at the carry LSB
			Q_POS2: csa_c = ~dvs_x2;
			default: csa_c = '0;
		endcase
	end

	assign maj       = (csa_a & csa_b) | (csa_a & csa_c) | (csa_b & csa_c);
	assign sum_nxt   = csa_a ^ csa_b ^ csa_c;
	assign carry_nxt = {maj[REM_W-2:0], (digit_q == Q_POS1) | (digit_q == Q_POS2)};

	// seven top bits of each vector estimate four times the new remainder
	assign y_est = $signed(sum_nxt[REM_W-1 -: 7] + carry_nxt[REM_W-1 -: 7]);

	always_comb begin
		if (y_est >= th_pos2) digit_nxt = Q_POS2;
		else if (y_est >= th_pos1) digit_nxt = Q_POS1;
		else if (y_est >= th_neg0) digit_nxt = Q_ZERO;
		else if (y_est >= th_neg1) digit_nxt = Q_NEG1;
		else digit_nxt = Q_NEG2;
	end

	always_comb begin
		unique case (digit_q)
			Q_POS2: begin
				quot_nxt    = {quot_o[XLEN-3:0], 2'b10};
				quot_m1_nxt = {quot_o[XLEN-3:0], 2'b01};
			end
			Q_POS1: begin
				quot_nxt    = {quot_o[XLEN-3:0], 2'b01};
				quot_m1_nxt = {quot_o[XLEN-3:0], 2'b00};
			end
			Q_NEG1: begin
				quot_nxt    = {quot_m1_o[XLEN-3:0], 2'b11}; // borrow taken from the minus-one copy
				quot_m1_nxt = {quot_m1_o[XLEN-3:0], 2'b10};
			end
			Q_NEG2: begin
				quot_nxt    = {quot_m1_o[XLEN-3:0], 2'b10};
				quot_m1_nxt = {quot_m1_o[XLEN-3:0], 2'b01};
			end
			default: begin
				quot_nxt    = {quot_o[XLEN-3:0], 2'b00};
				quot_m1_nxt = {quot_m1_o[XLEN-3:0], 2'b11};
			end
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (state_i == PRE1) begin
			rem_sum_o   <= rem_load;
			rem_carry_o <= '0;
			quot_o      <= divisor_zero_i ? '1 : too_big_i ? dividend_abs_i : '0;
			quot_m1_o   <= '1; // minus one of an empty quotient
			m_neg1_q    <= qds_m_neg1(row);
			m_neg0_q    <= qds_m_neg0(row);
			m_pos1_q    <= qds_m_pos1(row);
			m_pos2_q    <= qds_m_pos2(row);
		end else if (state_i == ITER) begin
			rem_sum_o   <= sum_nxt;
			rem_carry_o <= carry_nxt;
			quot_o      <= quot_nxt;
			quot_m1_o   <= quot_m1_nxt;
		end
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			digit_q <= Q_ZERO;
			cnt_q   <= '0;
		end else if (state_i == PRE1) begin
			digit_q <= pre_digit;
			cnt_q   <= iter_cnt_i;
		end else if (state_i == ITER) begin
			digit_q <= digit_nxt;
			cnt_q   <= cnt_q - 1'b1;
		end
	end

	assign final_iter_o = (cnt_q == '0); // the step with count zero is the last one

endmodule

// ==== div_prescale.sv ====
`timescale 1ns/1ns

module div_prescale #(
	parameter int XLEN = 32
) (
	input  logic                     clock_i,
	input  logic                     rst_n_i,
	input  div_ctrl_pkg::div_state_e state_i,
	input  logic                     in_valid_i,
	input  logic                     signed_i,
	input  logic [XLEN-1:0]          dividend_i,
	input  logic [XLEN-1:0]          divisor_i,
	output logic [XLEN-1:0]          dividend_abs_o,
	output logic [XLEN-1:0]          dividend_norm_o,
	output logic [XLEN-1:0]          divisor_norm_o,
	output logic                     divisor_zero_o,
	output logic                     too_big_o,
	output logic                     too_small_o,
	output logic                     skip_iter_o,
	output logic [$clog2(XLEN)-1:0]  iter_cnt_o,
	output logic                     lzc_odd_o,
	output logic [$clog2(XLEN)-1:0]  rem_shift_o,
	output logic                     quot_neg_o,
	output logic                     rem_neg_o
);

	import div_ctrl_pkg::*;

	localparam int CNT_W = $clog2(XLEN);

	logic             accept;
	logic             dividend_neg;
	logic             divisor_neg;
	logic [XLEN-1:0]  dividend_abs_q;
	logic [XLEN-1:0]  divisor_abs_q;
	logic [CNT_W-1:0] dvd_lzc;
	logic [CNT_W-1:0] dvs_lzc;
	logic             dvd_empty;
	logic             dvs_empty;
	logic             too_small_nxt;
	int               lzc_diff;

	assign accept       = (state_i == IDLE) & in_valid_i; // in_ready_o is the IDLE state itself
	assign dividend_neg = signed_i & dividend_i[XLEN-1];
	assign divisor_neg  = signed_i & divisor_i[XLEN-1];

	lzc #(.XLEN(XLEN)) u_lzc_dividend (
		.in_i    (dividend_abs_q),
		.cnt_o   (dvd_lzc),
		.empty_o (dvd_empty)
	);

	lzc #(.XLEN(XLEN)) u_lzc_divisor (
		.in_i    (divisor_abs_q),
		.cnt_o   (dvs_lzc),
		.empty_o (dvs_empty)
	);

	assign lzc_diff      = int'(dvs_lzc) - int'(dvd_lzc); // never negative on the iterating path
	assign too_small_nxt = dvd_empty | (dividend_abs_q < divisor_abs_q);

	always_ff @(posedge clock_i) begin
		if (accept) begin
			// the most negative value maps onto itself as unsigned
			dividend_abs_q <= dividend_neg ? -dividend_i : dividend_i;
			divisor_abs_q  <= divisor_neg ? -divisor_i : divisor_i;
		end
		if (state_i == PRE0) begin
			dividend_norm_o <= dividend_abs_q << dvd_lzc;
			divisor_norm_o  <= divisor_abs_q << dvs_lzc; // leading one lands in the top bit
			iter_cnt_o      <= too_small_nxt ? '0 : CNT_W'(half_up(lzc_diff));
			lzc_odd_o       <= is_odd(lzc_diff);
			rem_shift_o     <= (too_small_nxt | dvs_empty) ? '0 : dvs_lzc; // undo the divisor scaling
		end
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			quot_neg_o     <= 1'b0;
			rem_neg_o      <= 1'b0;
			divisor_zero_o <= 1'b0;
			too_big_o      <= 1'b0;
			too_small_o    <= 1'b0;
		end else if (accept) begin
			quot_neg_o <= dividend_neg ^ divisor_neg;
			rem_neg_o  <= dividend_neg; // remainder follows the dividend sign
		end else if (state_i == PRE0) begin
			quot_neg_o     <= quot_neg_o & ~dvs_empty; // all-ones quotient is never negated
			divisor_zero_o <= dvs_empty;
			too_big_o      <= (divisor_abs_q == XLEN'(1)) & dividend_abs_q[XLEN-1];
			too_small_o    <= too_small_nxt;
		end
	end

	assign dividend_abs_o = dividend_abs_q;
	assign skip_iter_o    = too_small_o | too_big_o | divisor_zero_o;

endmodule

// ==== div_ctrl.sv ====
`timescale 1ns/1ns

module div_ctrl (
	input  logic                     clock_i,
	input  logic                     rst_n_i,
	input  logic                     in_valid_i,
	input  logic                     out_ready_i,
	input  logic                     skip_iter_i,
	input  logic                     final_iter_i,
	output div_ctrl_pkg::div_state_e state_o,
	output logic                     in_ready_o,
	output logic                     out_valid_o
);

	import div_ctrl_pkg::*;

	div_state_e state_q;
	div_state_e state_nxt;

	always_comb begin
		state_nxt = state_q;
		unique case (state_q)
			IDLE: if (in_valid_i) state_nxt = PRE0; // in_ready_o is high in IDLE
			PRE0: state_nxt = PRE1;
			PRE1: state_nxt = skip_iter_i ? POS0 : ITER; // special cases need no digits
			ITER: if (final_iter_i) state_nxt = POS0;
			POS0: state_nxt = POS1;
			POS1: if (out_ready_i) state_nxt = IDLE; // hold the result under back-pressure
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) state_q <= IDLE;
		else state_q <= state_nxt;
	end

	assign state_o     = state_q;
	assign in_ready_o  = (state_q == IDLE);
	assign out_valid_o = (state_q == POS1);

endmodule

// ==== lzc.sv ====
`timescale 1ns/1ns

module lzc #(
	parameter int XLEN = 32
) (
	input  logic [XLEN-1:0]         in_i,
	output logic [$clog2(XLEN)-1:0] cnt_o,
	output logic                    empty_o
);

	localparam int CNT_W = $clog2(XLEN);

	logic [CNT_W-1:0] cnt;

	always_comb begin
		cnt = '0; // an all-zero input reports zero and raises empty_o
		for (int i = 0; i < XLEN; i++) begin
			if (in_i[i]) begin
				cnt = CNT_W'(XLEN - 1 - i); // the highest set bit is visited last and wins
			end
		end
	end

	assign cnt_o   = cnt;
	assign empty_o = ~|in_i;

endmodule

// ==== srt_qds_pkg.sv ====
package srt_qds_pkg;

	typedef enum logic [4:0] {
		Q_NEG2 = 5'b00001, // subtract nothing, add twice the divisor
		Q_NEG1 = 5'b00010,
		Q_ZERO = 5'b00100,
		Q_POS1 = 5'b01000,
		Q_POS2 = 5'b10000  // subtract twice the divisor
	} quot_digit_e;

	localparam int QDS_IDX_W = 3; // divisor bits right after the leading one

	// magnitude of the -1/-2 boundary, in sixteenths of the shifted remainder
	function automatic logic [4:0] qds_m_neg1(input logic [QDS_IDX_W-1:0] row);
		logic [4:0] m;
		case (row)
			3'd0: m = 5'd13;
			3'd1: m = 5'd15;
			3'd2: m = 5'd16;
			3'd3: m = 5'd17;
			3'd4: m = 5'd19;
			3'd5: m = 5'd20;
			3'd6: m = 5'd22;
			default: m = 5'd24;
		endcase
		return m;
	endfunction

	// half the magnitude of the 0/-1 boundary, all rows are even
	function automatic logic [2:0] qds_m_neg0(input logic [QDS_IDX_W-1:0] row);
		return (row == 3'd0) ? 3'd2 : (row < 3'd5) ? 3'd3 : 3'd4;
	endfunction

	// +1/0 boundary coded as value/2 - 2, giving 4, 6 or 8
	function automatic logic [1:0] qds_m_pos1(input logic [QDS_IDX_W-1:0] row);
		return (row < 3'd4) ? 2'd0 : (row < 3'd7) ? 2'd1 : 2'd2;
	endfunction

	function automatic logic [4:0] qds_m_pos2(input logic [QDS_IDX_W-1:0] row);
		logic [4:0] m;
		case (row)
			3'd0: m = 5'd12;
			3'd1: m = 5'd14;
			3'd2: m = 5'd15;
			3'd3: m = 5'd16;
			3'd4: m = 5'd18;
			3'd5: m = 5'd20;
			default: m = 5'd22; // rows 6 and 7 share the boundary
		endcase
		return m;
	endfunction

	// the first digit sees an exact positive remainder so plain values suffice
	function automatic logic [4:0] pre_m_pos1(input logic [QDS_IDX_W-1:0] row);
		return 5'({1'b0, qds_m_pos1(row)} + 3'd2) << 1;
	endfunction

	function automatic logic [4:0] pre_m_pos2(input logic [QDS_IDX_W-1:0] row);
		return qds_m_pos2(row);
	endfunction

endpackage

// ==== div_ctrl_pkg.sv ====
package div_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE = 3'd0, // waiting for an operand pair
		PRE0 = 3'd1, // magnitudes and signs sit in their registers
		PRE1 = 3'd2, // normalized operands and special-case flags are ready
		ITER = 3'd3, // one radix-4 digit per cycle
		POS0 = 3'd4, // remainder is resolved and corrected
		POS1 = 3'd5  // result is offered until the consumer takes it
	} div_state_e;

	// number of radix-4 steps after the first one, two quotient bits per step
	function automatic int half_up(input int diff);
		return (diff + 1) / 2;
	endfunction

	// an odd leading-zero difference starts the remainder one bit lower
	function automatic logic is_odd(input int diff);
		return diff[0];
	endfunction

endpackage
